//--- hw/exec_pkg.sv
`default_nettype none

package exec_pkg;

	////////////////////////////////////////////////////////////
	// widths and iteration count
	////////////////////////////////////////////////////////////

	localparam int word_width = 32;

	// one iteration per operand bit for both multi-cycle units.
	localparam int iter_count = word_width;

	// source select for the Z register.
	localparam logic [1:0] zsel_alu = 2'd0;
	localparam logic [1:0] zsel_mul = 2'd1;
	localparam logic [1:0] zsel_div = 2'd2;

	////////////////////////////////////////////////////////////
	// opcodes and sequencer states
	////////////////////////////////////////////////////////////

	typedef enum logic [4:0] {
		op_add  = 5'b00011,
		op_sub  = 5'b00100,
		op_shr  = 5'b00101,
		op_shra = 5'b00110,
		op_shl  = 5'b00111,
		op_ror  = 5'b01000,
		op_rol  = 5'b01001,
		op_and  = 5'b01010,
		op_or   = 5'b01011,
		op_mul  = 5'b01111,
		op_div  = 5'b10000,
		op_neg  = 5'b10001,
		op_not  = 5'b10010,
		op_br   = 5'b10011,
		op_inc  = 5'b11010
	} alu_op_t;

	typedef enum logic [2:0] {
		st_idle,
		st_alu,
		st_mul,
		st_div,
		st_done
	} exec_state_t;

endpackage

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import exec_pkg::*; (
	input  wire alu_op_t                 opcode,
	input  wire [word_width-1:0]         y,
	input  wire [word_width-1:0]         b,
	input  wire                          branch_flag,
	output logic [2*word_width-1:0]      result
);

	logic [word_width-1:0]   lo_res;
	logic [4:0]              sh_amt;
	logic [word_width-1:0]   sum;
	logic [word_width-1:0]   diff;
	logic [2*word_width-1:0] y_twice;
	logic [2*word_width-1:0] ror_full;
	logic [2*word_width-1:0] rol_full;

	assign sh_amt = b[4:0];
	assign sum    = y + b;
	assign diff   = y - b;

	// rotates work on a doubled copy of y.
	assign y_twice  = {y, y};
	assign ror_full = y_twice >> sh_amt;
	assign rol_full = y_twice << sh_amt;

	always_comb begin
		case (opcode)
			op_add: begin
				lo_res = sum;
			end
			op_sub: begin
				lo_res = diff;
			end
			op_and: begin
				lo_res = y & b;
			end
			op_or: begin
				lo_res = y | b;
			end
			op_neg: begin
				lo_res = -b;
			end
			op_not: begin
				lo_res = ~b;
			end
			op_shr: begin
				lo_res = y >> sh_amt;
			end
			op_shra: begin
				lo_res = $signed(y) >>> sh_amt;
			end
			op_shl: begin
				lo_res = y << sh_amt;
			end
			op_ror: begin
				lo_res = ror_full[word_width-1:0];
			end
			op_rol: begin
				lo_res = rol_full[2*word_width-1:word_width];
			end
			op_inc: begin
				lo_res = b + 1'b1;
			end
			op_br: begin
				// taken branch adds the offset, otherwise pass y through.
				if (branch_flag) begin
					lo_res = sum;
				end else begin
					lo_res = y;
				end
			end
			default: begin
				lo_res = '0;
			end
		endcase
	end

	// single-cycle results never reach the upper half.
	assign result = {{word_width{1'b0}}, lo_res};

endmodule

`default_nettype wire

//--- hw/booth_mul.sv
`timescale 1ns/10ps
`default_nettype none

module booth_mul import exec_pkg::*; (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      start,
	input  wire [word_width-1:0]     multiplicand,
	input  wire [word_width-1:0]     multiplier,
	output logic [2*word_width-1:0]  product,
	output logic                     finish
);

	localparam int cnt_w = $clog2(iter_count + 1);

	// accumulator carries one guard bit for the most negative operand.
	logic [word_width:0]     acc;
	logic [word_width-1:0]   q;
	logic                    q_prev;
	logic [word_width:0]     m_ext;
	logic [word_width:0]     sum;
	logic [cnt_w-1:0]        count;
	logic                    running;

	always_comb begin
		case ({q[0], q_prev})
			2'b01:   sum = acc + m_ext;
			2'b10:   sum = acc - m_ext;
			default: sum = acc;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc     <= '0;
			q       <= '0;
			q_prev  <= 1'b0;
			m_ext   <= '0;
			count   <= '0;
			running <= 1'b0;
			finish  <= 1'b0;
		end else begin
			finish <= 1'b0;
			if (start && !running) begin
				acc     <= '0;
				q       <= multiplier;
				q_prev  <= 1'b0;
				m_ext   <= {multiplicand[word_width-1], multiplicand};
				count   <= cnt_w'(iter_count);
				running <= 1'b1;
			end else if (running) begin
				// arithmetic shift right of {acc, q, q_prev}.
				acc    <= {sum[word_width], sum[word_width:1]};
				q      <= {sum[0], q[word_width-1:1]};
				q_prev <= q[0];
				count  <= count - 1'b1;
				if (count == cnt_w'(1)) begin
					running <= 1'b0;
					finish  <= 1'b1;
				end
			end
		end
	end

	assign product = {acc[word_width-1:0], q};

endmodule

`default_nettype wire

//--- hw/restoring_div.sv
`timescale 1ns/10ps
`default_nettype none

module restoring_div import exec_pkg::*; (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    start,
	input  wire [word_width-1:0]   dividend,
	input  wire [word_width-1:0]   divisor,
	output logic [word_width-1:0]  quotient,
	output logic [word_width-1:0]  remainder,
	output logic                   finish
);

	localparam int cnt_w = $clog2(iter_count + 1);

	logic [word_width-1:0]   rem;
	logic [word_width-1:0]   quo;
	logic [word_width-1:0]   dvs;
	logic [word_width:0]     rem_sh;
	logic [word_width+1:0]   trial;
	logic [cnt_w-1:0]        count;
	logic                    running;

	// shift the next dividend bit into the partial remainder.
	assign rem_sh = {rem, quo[word_width-1]};
	// negative trial means the subtraction is undone.
	assign trial  = {1'b0, rem_sh} - {2'b00, dvs};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rem     <= '0;
			quo     <= '0;
			dvs     <= '0;
			count   <= '0;
			running <= 1'b0;
			finish  <= 1'b0;
		end else begin
			finish <= 1'b0;
			if (start && !running) begin
				rem     <= '0;
				quo     <= dividend;
				dvs     <= divisor;
				count   <= cnt_w'(iter_count);
				running <= 1'b1;
			end else if (running) begin
				if (trial[word_width+1]) begin
					rem <= rem_sh[word_width-1:0];
					quo <= {quo[word_width-2:0], 1'b0};
				end else begin
					rem <= trial[word_width-1:0];
					quo <= {quo[word_width-2:0], 1'b1};
				end
				count <= count - 1'b1;
				if (count == cnt_w'(1)) begin
					running <= 1'b0;
					finish  <= 1'b1;
				end
			end
		end
	end

	assign quotient  = quo;
	assign remainder = rem;

endmodule

`default_nettype wire

//--- hw/exec_control.sv
`timescale 1ns/10ps
`default_nettype none

module exec_control import exec_pkg::*; (
	input  wire          clk,
	input  wire          rst_n,
	input  wire          start,
	input  wire alu_op_t opcode,
	input  wire          mul_finish,
	input  wire          div_finish,
	output logic         load_op,
	output logic         mul_start,
	output logic         div_start,
	output logic         z_load,
	output logic [1:0]   z_sel,
	output logic         busy,
	output logic         done
);

	exec_state_t state;
	logic        unit_finish;

	assign load_op = start && (state == st_idle);
	assign busy    = (state != st_idle);
	assign done    = (state == st_done);

	////////////////////////////////////////////////////////////
	// result source for the current path
	////////////////////////////////////////////////////////////

	always_comb begin
		case (state)
			st_alu: begin
				unit_finish = 1'b1;
				z_sel       = zsel_alu;
			end
			st_mul: begin
				unit_finish = mul_finish;
				z_sel       = zsel_mul;
			end
			st_div: begin
				unit_finish = div_finish;
				z_sel       = zsel_div;
			end
			default: begin
				unit_finish = 1'b0;
				z_sel       = zsel_alu;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// sequencer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= st_idle;
			mul_start <= 1'b0;
			div_start <= 1'b0;
			z_load    <= 1'b0;
		end else begin
			mul_start <= 1'b0;
			div_start <= 1'b0;
			case (state)
				st_idle: begin
					if (start) begin
						if (opcode == op_mul) begin
							state     <= st_mul;
							mul_start <= 1'b1;
						end else if (opcode == op_div) begin
							state     <= st_div;
							div_start <= 1'b1;
						end else begin
							state <= st_alu;
						end
					end
				end
				st_alu, st_mul, st_div: begin
					// Z takes the result on the edge after z_load rises.
					if (z_load) begin
						z_load <= 1'b0;
						state  <= st_done;
					end else if (unit_finish) begin
						z_load <= 1'b1;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

module exec_unit import exec_pkg::*; (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    start,
	input  wire alu_op_t           opcode,
	input  wire [word_width-1:0]   a,
	input  wire [word_width-1:0]   b,
	input  wire                    branch_flag,
	output logic [word_width-1:0]  hi,
	output logic [word_width-1:0]  lo,
	output logic                   busy,
	output logic                   done
);

	logic [word_width-1:0]   y_reg;
	logic [word_width-1:0]   b_reg;
	alu_op_t                 op_reg;
	logic                    br_reg;
	logic [2*word_width-1:0] z_reg;
	logic [2*word_width-1:0] alu_res;
	logic [2*word_width-1:0] mul_res;
	logic [word_width-1:0]   quo;
	logic [word_width-1:0]   rem;
	logic                    load_op;
	logic                    mul_start;
	logic                    div_start;
	logic                    mul_finish;
	logic                    div_finish;
	logic                    z_load;
	logic [1:0]              z_sel;

	exec_control u_ctrl (
		.clk(clk), .rst_n(rst_n), .start(start), .opcode(opcode),
		.mul_finish(mul_finish), .div_finish(div_finish), .load_op(load_op),
		.mul_start(mul_start), .div_start(div_start), .z_load(z_load),
		.z_sel(z_sel), .busy(busy), .done(done)
	);

	alu u_alu (
		.opcode(op_reg), .y(y_reg), .b(b_reg), .branch_flag(br_reg), .result(alu_res)
	);

	booth_mul u_mul (
		.clk(clk), .rst_n(rst_n), .start(mul_start), .multiplicand(y_reg),
		.multiplier(b_reg), .product(mul_res), .finish(mul_finish)
	);

	restoring_div u_div (
		.clk(clk), .rst_n(rst_n), .start(div_start), .dividend(y_reg),
		.divisor(b_reg), .quotient(quo), .remainder(rem), .finish(div_finish)
	);

	// operand capture.
	always_ff @(posedge clk) begin
		if (load_op) begin
			y_reg  <= a;
			b_reg  <= b;
			op_reg <= opcode;
			br_reg <= branch_flag;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			z_reg <= '0;
		end else if (z_load) begin
			case (z_sel)
				zsel_mul: z_reg <= mul_res;
				zsel_div: z_reg <= {rem, quo};
				default:  z_reg <= alu_res;
			endcase
		end
	end

	assign hi = z_reg[2*word_width-1:word_width];
	assign lo = z_reg[word_width-1:0];

endmodule

`default_nettype wire

//--- tests/exec_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module exec_unit_tb import exec_pkg::*; ();

	localparam int wait_limit  = 4 * iter_count + 40;
	localparam int alu_latency = 2;

	logic                  clk;
	logic                  rst_n;
	logic                  start;
	alu_op_t               opcode;
	logic [word_width-1:0] a;
	logic [word_width-1:0] b;
	logic                  branch_flag;
	wire  [word_width-1:0] hi;
	wire  [word_width-1:0] lo;
	wire                   busy;
	wire                   done;

	logic [31:0]             rand_state;
	int                      check_count = 0;
	int                      error_count = 0;
	string                   name_q[$];
	logic [2*word_width-1:0] exp_q[$];
	logic [2*word_width-1:0] act_q[$];

	exec_unit uut (
		.clk(clk), .rst_n(rst_n), .start(start), .opcode(opcode), .a(a), .b(b),
		.branch_flag(branch_flag), .hi(hi), .lo(lo), .busy(busy), .done(done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// stimulus helpers and reference model
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		rand_state = rand_state ^ (rand_state << 13);
		rand_state = rand_state ^ (rand_state >> 17);
		rand_state = rand_state ^ (rand_state << 5);
		return rand_state;
	endfunction

	function automatic logic [2*word_width-1:0] ref_result(input alu_op_t op,
			input logic [word_width-1:0] y_op, input logic [word_width-1:0] b_op,
			input logic br);
		logic [word_width-1:0]          r;
		logic signed [2*word_width-1:0] sy;
		logic signed [2*word_width-1:0] sb;
		int                             n;
		r  = '0;
		n  = int'(b_op[4:0]);
		sy = $signed(y_op);
		sb = $signed(b_op);
		case (op)
			op_add:  r = y_op + b_op;
			op_sub:  r = y_op - b_op;
			op_and:  r = y_op & b_op;
			op_or:   r = y_op | b_op;
			op_neg:  r = 32'd0 - b_op;
			op_not:  r = ~b_op;
			op_shr:  r = y_op >> n;
			op_shra: r = $signed(y_op) >>> n;
			op_shl:  r = y_op << n;
			op_inc:  r = b_op + 32'd1;
			op_br:   r = br ? y_op + b_op : y_op;
			op_ror: begin
				r = y_op;
				for (int i = 0; i < n; i++) begin
					r = {r[0], r[word_width-1:1]};
				end
			end
			op_rol: begin
				r = y_op;
				for (int i = 0; i < n; i++) begin
					r = {r[word_width-2:0], r[word_width-1]};
				end
			end
			op_mul:  return sy * sb;
			op_div: begin
				// divide by zero leaves all-ones and the dividend.
				if (b_op == '0) begin
					return {y_op, {word_width{1'b1}}};
				end
				return {y_op % b_op, y_op / b_op};
			end
			default: r = '0;
		endcase
		return {{word_width{1'b0}}, r};
	endfunction

	task automatic post_check(input string name, input logic [63:0] exp_val,
			input logic [63:0] act_val);
		name_q.push_back(name);
		exp_q.push_back(exp_val);
		act_q.push_back(act_val);
	endtask

	task automatic stop_on_timeout(input string what);
		$display("ERROR: no response within %0d cycles during %s", wait_limit, what);
		$display("checks: %0d, errors: %0d, timeouts: 1", check_count, error_count);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	task automatic wait_for_done(input string name, output int cycles);
		cycles = 0;
		while (!done && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			stop_on_timeout(name);
		end
	endtask

	task automatic run_op(input string name, input alu_op_t op,
			input logic [word_width-1:0] y_op, input logic [word_width-1:0] b_op,
			input logic br, input bit check_latency);
		int cycles;
		opcode      = op;
		a           = y_op;
		b           = b_op;
		branch_flag = br;
		start       = 1'b1;
		@(negedge clk);
		start = 1'b0;
		wait_for_done(name, cycles);
		post_check(name, ref_result(op, y_op, b_op, br), {hi, lo});
		if (check_latency) begin
			post_check({name, " latency"}, 64'(alu_latency), 64'(cycles));
		end
		// the sequencer needs one more edge to get back to idle.
		@(negedge clk);
	endtask

	////////////////////////////////////////////////////////////
	// comparison
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		string                   nm;
		logic [2*word_width-1:0] e;
		logic [2*word_width-1:0] r;
		while (name_q.size() > 0) begin
			nm = name_q.pop_front();
			e  = exp_q.pop_front();
			r  = act_q.pop_front();
			check_count++;
			if (r !== e) begin
				error_count++;
				$display("CHECK FAILED %s: expected %h, actual %h", nm, e, r);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		alu_op_t               single_ops[12];
		logic [word_width-1:0] mul_y[6];
		logic [word_width-1:0] mul_b[6];
		logic [word_width-1:0] x;
		logic [word_width-1:0] y;
		logic [63:0]           first_res;
		int                    cycles;
		int                    done_count;
		int                    drain;

		rst_n       = 1'b0;
		start       = 1'b0;
		opcode      = op_add;
		a           = '0;
		b           = '0;
		branch_flag = 1'b0;
		rand_state  = 32'd85543;
		single_ops  = '{op_add, op_sub, op_shr, op_shra, op_shl, op_ror, op_rol,
			op_and, op_or, op_neg, op_not, op_inc};
		mul_y = '{32'h8000_0000, 32'h8000_0000, 32'hffff_ffff, 32'h0,
			32'h7fff_ffff, 32'h8000_0000};
		mul_b = '{32'h8000_0000, 32'hffff_ffff, 32'hffff_ffff, 32'h1234_5678,
			32'h8000_0000, 32'h0};

		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		post_check("reset busy", 64'd0, 64'(busy));
		post_check("reset done", 64'd0, 64'(done));
		post_check("reset z", 64'd0, {hi, lo});

		foreach (single_ops[i]) begin
			for (int k = 0; k < 4; k++) begin
				x = next_rand();
				y = next_rand();
				run_op(single_ops[i].name(), single_ops[i], x, y, y[7], 1'b1);
			end
		end
		run_op("ror by zero", op_ror, 32'h8000_0001, 32'h20, 1'b0, 1'b1);
		run_op("rol by zero", op_rol, 32'h8000_0001, 32'h40, 1'b0, 1'b1);
		for (int k = 0; k < 4; k++) begin
			x = next_rand();
			y = next_rand();
			run_op("branch taken", op_br, x, y, 1'b1, 1'b1);
			run_op("branch not taken", op_br, x, y, 1'b0, 1'b1);
		end

		// signed multiply, corners first.
		foreach (mul_y[i]) begin
			run_op("mul corner", op_mul, mul_y[i], mul_b[i], 1'b0, 1'b0);
		end
		for (int k = 0; k < 8; k++) begin
			x = next_rand();
			y = next_rand();
			run_op("mul random", op_mul, x, y, 1'b0, 1'b0);
		end

		for (int k = 0; k < 8; k++) begin
			x = next_rand();
			y = next_rand();
			y = y >> x[4:0];
			run_op("div random", op_div, x, y, 1'b0, 1'b0);
		end
		run_op("div by zero", op_div, next_rand(), 32'h0, 1'b0, 1'b0);
		run_op("div small dividend", op_div, 32'd5, 32'd9, 1'b0, 1'b0);

		run_op("undefined opcode 0", alu_op_t'(5'd0), next_rand(), next_rand(), 1'b1, 1'b1);
		run_op("undefined opcode 31", alu_op_t'(5'd31), next_rand(), next_rand(), 1'b0, 1'b1);

		// a second start pulsed halfway through a multiply must be dropped.
		x           = next_rand();
		y           = next_rand();
		opcode      = op_mul;
		a           = x;
		b           = y;
		branch_flag = 1'b0;
		start       = 1'b1;
		@(negedge clk);
		start = 1'b0;
		repeat (iter_count / 2) @(negedge clk);
		post_check("busy during multiply", 64'd1, 64'(busy));
		opcode = op_add;
		a      = next_rand();
		b      = next_rand();
		start  = 1'b1;
		@(negedge clk);
		start = 1'b0;
		wait_for_done("multiply with ignored start", cycles);
		first_res  = {hi, lo};
		done_count = 1;
		for (int k = 0; k < iter_count + 8; k++) begin
			@(negedge clk);
			if (done) begin
				done_count++;
			end
		end
		post_check("ignored start result", ref_result(op_mul, x, y, 1'b0), first_res);
		post_check("ignored start done count", 64'd1, 64'(done_count));

		drain = 0;
		while (name_q.size() > 0 && drain < wait_limit) begin
			@(negedge clk);
			drain++;
		end
		if (name_q.size() > 0) begin
			stop_on_timeout("result comparison");
		end else begin
			$display("checks: %0d, errors: %0d, timeouts: 0", check_count, error_count);
			if (error_count == 0) begin
				$display("SIMULATION PASSED");
			end else begin
				$display("SIMULATION FAILED");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- vlog.f
hw/exec_pkg.sv
hw/alu.sv
hw/booth_mul.sv
hw/restoring_div.sv
hw/exec_control.sv
hw/exec_unit.sv
tests/exec_unit_tb.sv

//--- Bender.yml
package:
  name: exec_unit

sources:
  - hw/exec_pkg.sv
  - hw/alu.sv
  - hw/booth_mul.sv
  - hw/restoring_div.sv
  - hw/exec_control.sv
  - hw/exec_unit.sv
  - target: test
    files:
      - tests/exec_unit_tb.sv
